//--- common/core_pkg.sv
/*
 * Core package
 * Word and register geometry, RV32I opcode and funct constants,
 * ALU operation encoding and the payload structs carried between
 * the decode, execute and result stages
 */
package core_pkg;

  // Word and register file geometry
  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]             word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_addr_t;

  //////////////////////////////
  // Instruction encoding
  //////////////////////////////

  // Major opcodes of the supported groups
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  // funct3 field, shared by OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 field
  localparam logic [6:0] F7_BASE = 7'b0000000;
  // SUB and SRA / SRAI variant
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ALU operations, PASSB forwards operand B for LUI
  typedef enum logic [3:0] {
    ALU_ADD   = 4'd0,
    ALU_SUB   = 4'd1,
    ALU_AND   = 4'd2,
    ALU_OR    = 4'd3,
    ALU_XOR   = 4'd4,
    ALU_SLT   = 4'd5,
    ALU_SLTU  = 4'd6,
    ALU_SLL   = 4'd7,
    ALU_SRL   = 4'd8,
    ALU_SRA   = 4'd9,
    ALU_PASSB = 4'd10
  } alu_op_e;

  //////////////////////////////
  // Stage payloads
  //////////////////////////////

  // Decode to execute
  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    reg_addr_t rd;
    logic      we;
    logic      illegal;
  } id_ex_t;

  // Execute to write-back
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    logic      we;
    word_t     result;
    logic      illegal;
  } ex_wb_t;

endpackage

//--- common/pipe_if.sv
/*
 * Pipeline register interface
 * Carries one stage payload of any packed type from its
 * producer to its consumer, with a read-only tap used by
 * the operand bypass in decode
 */
interface pipe_if #(
  parameter type PAYLOAD_T = logic
);

  // Whole stage payload, valid bit included
  PAYLOAD_T payload;

  // Producing stage
  modport src (
    output payload
  );

  // Consuming stage
  modport dst (
    input payload
  );

  // Bypass tap
  // observes the payload without owning it
  modport fwd (
    input payload
  );

endinterface

//--- hw/decode/register_file.sv
/*
 * Register file
 * 31 writable registers with x0 hardwired to zero,
 * one synchronous write port and two asynchronous read ports
 */
module register_file import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  reg_addr_t raddr_a_i,
  input  reg_addr_t raddr_b_i,
  input  word_t     wdata_i,
  output word_t     rdata_a_o,
  output word_t     rdata_b_o
);

  // No storage behind x0
  word_t regs_q [1:NUM_REGS-1];

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      // Architectural state starts at zero
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  //////////////////////////////
  // Read ports
  //////////////////////////////

  // x0 always reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- hw/decode/decode_stage.sv
/*
 * Decode stage
 * Registers the incoming instruction, decodes the OP, OP-IMM
 * and LUI groups, selects operands with EX and WB bypass over
 * the register file and loads the ID/EX pipeline register
 */
module decode_stage import core_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  logic      instr_valid_i,
  input  word_t     instr_i,
  pipe_if.src       id_ex_if,
  pipe_if.fwd       ex_fwd_if,
  input  logic      wb_we_i,
  input  reg_addr_t wb_rd_i,
  input  word_t     wb_data_i
);

  word_t      instr_q;
  logic       instr_valid_q;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd, rs1, rs2;
  word_t      imm_i, imm_u;
  word_t      rf_rdata_a, rf_rdata_b;
  word_t      rs1_val, rs2_val;
  alu_op_e    base_op, alu_op;
  logic       legal, imm_sel, upper_sel;
  id_ex_t     id_ex_d, id_ex_q;

  // EX result first, then WB data, then the register file
  function automatic word_t bypass(input reg_addr_t rs, input word_t rf_val,
                                   input ex_wb_t ex_p, input logic wb_we,
                                   input reg_addr_t wb_rd, input word_t wb_data);
    if (ex_p.valid && ex_p.we && ex_p.rd == rs)
      return ex_p.result;
    if (wb_we && wb_rd == rs)
      return wb_data;
    return rf_val;
  endfunction

  // Instruction register, payload has no reset
  always_ff @(posedge clk_i) begin
    instr_q <= instr_i;
    if (rst_i)
      instr_valid_q <= 1'b0;
    else
      instr_valid_q <= instr_valid_i;
  end

  // Field extraction
  assign opcode = instr_q[6:0];
  assign rd     = instr_q[11:7];
  assign funct3 = instr_q[14:12];
  assign rs1    = instr_q[19:15];
  assign rs2    = instr_q[24:20];
  assign funct7 = instr_q[31:25];
  // Sign-extended I and zero-filled U immediates
  assign imm_i  = {{(XLEN-12){instr_q[31]}}, instr_q[31:20]};
  assign imm_u  = {instr_q[31:12], 12'b0};

  // Base operation per funct3
  always_comb begin
    case (funct3)
      F3_ADD_SUB: base_op = ALU_ADD;
      F3_SLL:     base_op = ALU_SLL;
      F3_SLT:     base_op = ALU_SLT;
      F3_SLTU:    base_op = ALU_SLTU;
      F3_XOR:     base_op = ALU_XOR;
      F3_SRL_SRA: base_op = ALU_SRL;
      F3_OR:      base_op = ALU_OR;
      default:    base_op = ALU_AND;
    endcase
  end

  // Main decoder
  always_comb begin
    alu_op    = base_op;
    legal     = 1'b0;
    imm_sel   = 1'b0;
    upper_sel = 1'b0;
    case (opcode)
      OPC_OP: begin
        // Only SUB and SRA take the alternate funct7
        legal = (funct7 == F7_BASE) ||
                (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
        if (funct7 == F7_ALT)
          alu_op = (funct3 == F3_ADD_SUB) ? ALU_SUB : ALU_SRA;
      end
      OPC_OP_IMM: begin
        imm_sel = 1'b1;
        // Shift immediates constrain funct7
        if (funct3 == F3_SLL)
          legal = (funct7 == F7_BASE);
        else if (funct3 == F3_SRL_SRA)
          legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
        else
          legal = 1'b1;
        if (funct3 == F3_SRL_SRA && funct7 == F7_ALT)
          alu_op = ALU_SRA;
      end
      OPC_LUI: begin
        legal     = 1'b1;
        upper_sel = 1'b1;
        alu_op    = ALU_PASSB;
      end
      default: legal = 1'b0;
    endcase
  end

  // Operand bypass
  assign rs1_val = bypass(rs1, rf_rdata_a, ex_fwd_if.payload, wb_we_i, wb_rd_i, wb_data_i);
  assign rs2_val = bypass(rs2, rf_rdata_b, ex_fwd_if.payload, wb_we_i, wb_rd_i, wb_data_i);

  // ID/EX payload, x0 destination never writes
  always_comb begin
    id_ex_d.valid   = instr_valid_q;
    id_ex_d.alu_op  = alu_op;
    id_ex_d.op_a    = rs1_val;
    id_ex_d.op_b    = upper_sel ? imm_u : (imm_sel ? imm_i : rs2_val);
    id_ex_d.rd      = rd;
    id_ex_d.we      = instr_valid_q && legal && (rd != '0);
    id_ex_d.illegal = instr_valid_q && !legal;
  end

  // ID/EX register, control bits cleared on reset
  always_ff @(posedge clk_i) begin
    id_ex_q <= id_ex_d;
    if (rst_i) begin
      id_ex_q.valid   <= 1'b0;
      id_ex_q.we      <= 1'b0;
      id_ex_q.illegal <= 1'b0;
    end
  end

  assign id_ex_if.payload = id_ex_q;

  // Register file, written from the WB register
  register_file register_file_i (
    .clk_i     ( clk_i      ),
    .rst_i     ( rst_i      ),
    .we_i      ( wb_we_i    ),
    .waddr_i   ( wb_rd_i    ),
    .raddr_a_i ( rs1        ),
    .raddr_b_i ( rs2        ),
    .wdata_i   ( wb_data_i  ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b )
  );

endmodule

//--- hw/execute/execute_stage.sv
/*
 * Execute stage
 * Combinational ALU turning the ID/EX payload into the
 * EX/WB payload within the same cycle
 */
module execute_stage import core_pkg::*; (
  pipe_if.dst id_ex_if,
  pipe_if.src ex_wb_if
);

  id_ex_t     in_p;
  ex_wb_t     out_p;
  word_t      op_a;
  word_t      op_b;
  logic [4:0] shamt;
  word_t      result;

  assign in_p  = id_ex_if.payload;
  assign op_a  = in_p.op_a;
  assign op_b  = in_p.op_b;
  // Shift amount from low bits of operand B
  assign shamt = op_b[4:0];

  //////////////////////////////
  // ALU
  //////////////////////////////
  always_comb begin
    case (in_p.alu_op)
      ALU_ADD:   result = op_a + op_b;
      ALU_SUB:   result = op_a - op_b;
      ALU_AND:   result = op_a & op_b;
      ALU_OR:    result = op_a | op_b;
      ALU_XOR:   result = op_a ^ op_b;
      // Compare results are zero-extended flags
      ALU_SLT:   result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:  result = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:   result = op_a << shamt;
      ALU_SRL:   result = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:   result = word_t'($signed(op_a) >>> shamt);
      // LUI
      ALU_PASSB: result = op_b;
      default:   result = '0;
    endcase
  end

  //////////////////////////////
  // EX/WB payload
  //////////////////////////////

  // Control fields pass through untouched
  always_comb begin
    out_p.valid   = in_p.valid;
    out_p.rd      = in_p.rd;
    out_p.we      = in_p.we;
    out_p.result  = result;
    out_p.illegal = in_p.illegal;
  end

  // Also seen by decode as the EX bypass
  assign ex_wb_if.payload = out_p;

endmodule

//--- hw/result_stage.sv
/*
 * Result stage
 * Write-back pipeline register, write-back outputs and a
 * wrapping counter of retired instructions
 */
module result_stage import core_pkg::*; #(
  parameter int RETIRE_CNT_W = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  pipe_if.dst                     ex_wb_if,
  output logic                    wb_valid_o,
  output logic                    wb_we_o,
  output logic                    wb_illegal_o,
  output reg_addr_t               wb_rd_o,
  output word_t                   wb_data_o,
  output logic [RETIRE_CNT_W-1:0] retire_count_o
);

  ex_wb_t                  wb_q;
  logic [RETIRE_CNT_W-1:0] retire_cnt_q;

  // WB register, control bits cleared on reset
  always_ff @(posedge clk_i) begin
    wb_q <= ex_wb_if.payload;
    if (rst_i) begin
      wb_q.valid   <= 1'b0;
      wb_q.we      <= 1'b0;
      wb_q.illegal <= 1'b0;
    end
  end

  // Retire counter
  // counts illegal ones too and wraps at full width
  always_ff @(posedge clk_i) begin
    if (rst_i)
      retire_cnt_q <= '0;
    else if (ex_wb_if.payload.valid)
      retire_cnt_q <= retire_cnt_q + 1'b1;
  end

  // Outputs straight from the register
  assign wb_valid_o     = wb_q.valid;
  assign wb_we_o        = wb_q.we;
  assign wb_illegal_o   = wb_q.illegal;
  assign wb_rd_o        = wb_q.rd;
  assign wb_data_o      = wb_q.result;
  assign retire_count_o = retire_cnt_q;

endmodule

//--- hw/core_top.sv
/*
 * RV32I integer pipeline top level
 * Three stages (decode, execute, result) fed by a plain
 * instruction strobe, with EX and WB bypass into decode
 * and registered write-back outputs plus a retire count
 */
module core_top import core_pkg::*; #(
  parameter int RETIRE_CNT_W = 16
) (
  input  logic                    clk_i,
  input  logic                    rst_i,

  // Instruction strobe
  input  logic                    instr_valid_i,
  input  word_t                   instr_i,

  // Write-back view of retired instructions
  output logic                    wb_valid_o,
  output logic                    wb_we_o,
  output logic                    wb_illegal_o,
  output reg_addr_t               wb_rd_o,
  output word_t                   wb_data_o,
  output logic [RETIRE_CNT_W-1:0] retire_count_o
);

  // Register file write port, fed back from result stage
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;

  // Stage boundaries
  pipe_if #(.PAYLOAD_T(id_ex_t)) id_ex_if ();
  pipe_if #(.PAYLOAD_T(ex_wb_t)) ex_wb_if ();

  //////////////////////////////
  // Decode
  //////////////////////////////
  decode_stage decode_stage_i (
    .clk_i         ( clk_i         ),
    .rst_i         ( rst_i         ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .id_ex_if      ( id_ex_if      ),
    .ex_fwd_if     ( ex_wb_if      ),
    .wb_we_i       ( wb_we         ),
    .wb_rd_i       ( wb_rd         ),
    .wb_data_i     ( wb_data       )
  );

  //////////////////////////////
  // Execute
  //////////////////////////////
  execute_stage execute_stage_i (
    .id_ex_if ( id_ex_if ),
    .ex_wb_if ( ex_wb_if )
  );

  //////////////////////////////
  // Result
  //////////////////////////////
  result_stage #(
    .RETIRE_CNT_W ( RETIRE_CNT_W )
  ) result_stage_i (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .ex_wb_if       ( ex_wb_if       ),
    .wb_valid_o     ( wb_valid_o     ),
    .wb_we_o        ( wb_we          ),
    .wb_illegal_o   ( wb_illegal_o   ),
    .wb_rd_o        ( wb_rd          ),
    .wb_data_o      ( wb_data        ),
    .retire_count_o ( retire_count_o )
  );

  // Same values go out on the ports
  assign wb_we_o   = wb_we;
  assign wb_rd_o   = wb_rd;
  assign wb_data_o = wb_data;

endmodule

//--- testbench/core_asserts.sv
/*
 * Core port assertions
 * Reset, write-back consistency and fixed pipeline latency
 * checks, bound into the core top level
 */
module core_asserts import core_pkg::*; (
  input logic      clk_i,
  input logic      rst_i,
  input logic      instr_valid_i,
  input logic      wb_valid_i,
  input logic      wb_we_i,
  input logic      wb_illegal_i,
  input reg_addr_t wb_rd_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failures seen so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // No retirement while reset is held
  reset_clears_valid: assert property (@(posedge clk_i)
    rst_i && $past(rst_i) |-> !wb_valid_i)
    else begin
      fail_cnt++;
      $error("wb_valid_o high during reset");
    end

  // An illegal instruction never writes
  no_write_when_illegal: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_valid_i |-> !(wb_we_i && wb_illegal_i))
    else begin
      fail_cnt++;
      $error("wb_we_o and wb_illegal_o high together");
    end

  no_write_to_x0: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_we_i |-> wb_rd_i != '0)
    else begin
      fail_cnt++;
      $error("write-back enabled for x0");
    end

  // Fixed latency, no stalls
  fixed_latency: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_valid_i |-> ##3 wb_valid_i)
    else begin
      fail_cnt++;
      $error("instruction did not retire three cycles after issue");
    end

endmodule

bind core_top core_asserts asserts_i (
  .clk_i         ( clk_i         ),
  .rst_i         ( rst_i         ),
  .instr_valid_i ( instr_valid_i ),
  .wb_valid_i    ( wb_valid_o    ),
  .wb_we_i       ( wb_we_o       ),
  .wb_illegal_i  ( wb_illegal_o  ),
  .wb_rd_i       ( wb_rd_o       )
);

//--- testbench/tb_core_model.svh
/*
 * Reference model for the core testbench
 * Shadow register file kept in program order and a function
 * that predicts the write-back fields of one instruction
 */
`ifndef TB_CORE_MODEL_SVH
`define TB_CORE_MODEL_SVH

// Expected write-back view of one instruction
typedef struct {
  logic        we;
  logic [4:0]  rd;
  logic [31:0] data;
  logic        illegal;
} expect_t;

// Architectural state, x0 never written
logic [31:0] shadow_regs [32];

function automatic expect_t predict(input logic [31:0] instr);
  expect_t     e;
  logic [6:0]  opc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] r;
  logic        ok;
  logic        alt;
  opc = instr[6:0];
  f3  = instr[14:12];
  f7  = instr[31:25];
  a   = shadow_regs[instr[19:15]];
  b   = shadow_regs[instr[24:20]];
  ok  = 1'b0;
  alt = 1'b0;
  r   = '0;
  if (opc == 7'b0110011) begin
    // Register-register, alternate funct7 only for SUB and SRA
    ok  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    alt = (f7 == 7'h20);
  end else if (opc == 7'b0010011) begin
    // Immediate group, I immediate sign-extended
    b = {{20{instr[31]}}, instr[31:20]};
    if (f3 == 3'd1)
      ok = (f7 == 7'h00);
    else if (f3 == 3'd5)
      ok = (f7 == 7'h00) || (f7 == 7'h20);
    else
      ok = 1'b1;
    alt = (f3 == 3'd5) && (f7 == 7'h20);
  end else if (opc == 7'b0110111) begin
    ok = 1'b1;
  end
  if (opc == 7'b0110111) begin
    r = {instr[31:12], 12'h000};
  end else begin
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: r = (a < b) ? 32'd1 : 32'd0;
      3'd4: r = a ^ b;
      3'd5: begin
        // Arithmetic versus logical right shift
        if (alt)
          r = $signed(a) >>> b[4:0];
        else
          r = a >> b[4:0];
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
  end
  e.we      = ok && (instr[11:7] != 5'd0);
  e.rd      = instr[11:7];
  e.data    = r;
  e.illegal = !ok;
  return e;
endfunction

// Program-order commit into the shadow state
task automatic update_shadow(input expect_t e);
  if (e.we)
    shadow_regs[e.rd] = e.data;
endtask

task automatic clear_shadow();
  foreach (shadow_regs[i])
    shadow_regs[i] = '0;
endtask

`endif

//--- testbench/tb_core.sv
/*
 * Core testbench
 * Directed and random RV32I ALU instructions driven through the
 * pipeline, write-back results compared in order against the
 * reference model, plus retire count and timeout checks
 */
module tb_core;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RETIRE_CNT_W   = 16;
  localparam int SEED           = 71364;
  localparam int RESET_CYCLES   = 4;
  localparam int PIPE_DEPTH     = 3;
  localparam int NUM_RANDOM     = 400;
  localparam int MAX_GAP        = 3;
  // Upper bound of directed issue and idle slots
  localparam int DIRECTED_SLOTS = 100;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_SLOTS +
                                  NUM_RANDOM * (1 + MAX_GAP) + PIPE_DEPTH + 20;

  logic                    clk_i = 1'b0;
  logic                    rst_i;
  logic                    instr_valid_i;
  logic [31:0]             instr_i;
  logic                    wb_valid_o;
  logic                    wb_we_o;
  logic                    wb_illegal_o;
  logic [4:0]              wb_rd_o;
  logic [31:0]             wb_data_o;
  logic [RETIRE_CNT_W-1:0] retire_count_o;

  `include "tb_core_model.svh"

  // Expectations in issue order
  expect_t exp_q [$];
  int      issued    = 0;
  int      cycle_cnt = 0;

  core_top #(
    .RETIRE_CNT_W ( RETIRE_CNT_W )
  ) uut (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .instr_valid_i  ( instr_valid_i  ),
    .instr_i        ( instr_i        ),
    .wb_valid_o     ( wb_valid_o     ),
    .wb_we_o        ( wb_we_o        ),
    .wb_illegal_o   ( wb_illegal_o   ),
    .wb_rd_o        ( wb_rd_o        ),
    .wb_data_o      ( wb_data_o      ),
    .retire_count_o ( retire_count_o )
  );

  always #5 clk_i = ~clk_i;

  //////////////////////////////
  // Reporting
  //////////////////////////////
  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_val(input string what, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0.1f ns: %s is %08h, expected %08h",
               $realtime, what, actual, expected);
      $display("** FAIL **");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Hang guard
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
      stop_with_failure("Timeout: the run did not finish within the cycle limit");
  end

  //////////////////////////////
  // Encoders
  //////////////////////////////
  function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  // Mostly legal, small register range for dense hazards
  function automatic logic [31:0] random_instr();
    logic [31:0] w;
    logic [6:0]  f7;
    logic [2:0]  f3;
    int          kind;
    int          pick;
    w    = $urandom();
    kind = $urandom_range(0, 9);
    pick = $urandom_range(0, 7);
    f3   = 3'($urandom_range(0, 7));
    if (pick < 5)
      f7 = 7'h00;
    else if (pick < 7)
      f7 = 7'h20;
    else
      f7 = w[31:25];
    if (kind < 4)
      return r_format(f7, 5'($urandom_range(0, 7)), 5'($urandom_range(0, 7)), f3,
                      5'($urandom_range(0, 7)));
    if (kind < 7) begin
      // Shift immediates carry funct7 in the top bits
      if (f3 == 3'd1 || f3 == 3'd5)
        w[31:25] = f7;
      return i_format(w[31:20], 5'($urandom_range(0, 7)), f3, 5'($urandom_range(0, 7)));
    end
    if (kind == 7)
      return u_format(w[31:12], 5'($urandom_range(0, 7)));
    if (kind == 8)
      return {w[31:7], 7'($urandom())};
    return w;
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  task automatic issue(input logic [31:0] instr);
    expect_t e;
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    instr_i       = instr;
    e = predict(instr);
    exp_q.push_back(e);
    update_shadow(e);
    issued++;
  endtask

  // Junk on instr_i while idle
  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      instr_valid_i = 1'b0;
      instr_i       = $urandom();
    end
  endtask

  task automatic immediate_tests();
    issue(i_format(12'd100, 5'd0, 3'd0, 5'd1));
    // Negative immediate
    issue(i_format(12'hfff, 5'd0, 3'd0, 5'd2));
    issue(i_format(12'h0f0, 5'd2, 3'd7, 5'd3));
    issue(i_format(12'hf00, 5'd1, 3'd6, 5'd4));
    issue(i_format(12'h555, 5'd2, 3'd4, 5'd5));
    issue(i_format(12'd1, 5'd2, 3'd2, 5'd6));
    issue(i_format(12'd1, 5'd2, 3'd3, 5'd7));
    // SLTIU against sign-extended all ones
    issue(i_format(12'hfff, 5'd1, 3'd3, 5'd8));
    issue(i_format(12'h004, 5'd1, 3'd1, 5'd9));
    issue(i_format(12'h01c, 5'd2, 3'd5, 5'd10));
    issue(u_format(20'h80000, 5'd12));
    // SRAI on a negative value
    issue(i_format(12'h404, 5'd12, 3'd5, 5'd13));
    issue(u_format(20'h12345, 5'd14));
    issue(i_format(12'h800, 5'd14, 3'd0, 5'd11));
    idle(2);
  endtask

  task automatic register_tests();
    issue(i_format(12'd7, 5'd0, 3'd0, 5'd20));
    // SUB borrow
    issue(r_format(7'h20, 5'd1, 5'd0, 3'd0, 5'd15));
    issue(r_format(7'h20, 5'd2, 5'd1, 3'd0, 5'd16));
    // Signed versus unsigned compare
    issue(r_format(7'h00, 5'd1, 5'd2, 3'd2, 5'd17));
    issue(r_format(7'h00, 5'd1, 5'd2, 3'd3, 5'd18));
    issue(r_format(7'h20, 5'd20, 5'd12, 3'd5, 5'd19));
    issue(r_format(7'h00, 5'd20, 5'd12, 3'd5, 5'd21));
    issue(r_format(7'h00, 5'd20, 5'd14, 3'd1, 5'd22));
    issue(r_format(7'h00, 5'd15, 5'd14, 3'd0, 5'd23));
    issue(r_format(7'h00, 5'd14, 5'd2, 3'd7, 5'd24));
    issue(r_format(7'h00, 5'd12, 5'd1, 3'd6, 5'd25));
    issue(r_format(7'h00, 5'd2, 5'd14, 3'd4, 5'd26));
    idle(2);
  endtask

  task automatic forwarding_tests();
    // Distance 1, EX bypass on both operand ports
    issue(i_format(12'd7, 5'd0, 3'd0, 5'd1));
    issue(i_format(12'd3, 5'd1, 3'd0, 5'd1));
    issue(r_format(7'h00, 5'd1, 5'd1, 3'd0, 5'd1));
    issue(r_format(7'h00, 5'd1, 5'd0, 3'd0, 5'd2));
    // Distance 2, WB bypass
    issue(i_format(12'hffb, 5'd0, 3'd0, 5'd3));
    issue(i_format(12'd9, 5'd0, 3'd0, 5'd4));
    issue(r_format(7'h00, 5'd0, 5'd3, 3'd0, 5'd5));
    issue(r_format(7'h00, 5'd4, 5'd0, 3'd4, 5'd6));
    // Distance 3, register file read after write
    issue(i_format(12'h03c, 5'd0, 3'd0, 5'd7));
    issue(i_format(12'd1, 5'd0, 3'd0, 5'd8));
    issue(i_format(12'd2, 5'd0, 3'd0, 5'd9));
    issue(r_format(7'h00, 5'd0, 5'd7, 3'd6, 5'd10));
    issue(r_format(7'h20, 5'd8, 5'd0, 3'd0, 5'd11));
    issue(r_format(7'h00, 5'd11, 5'd11, 3'd0, 5'd12));
    idle(2);
  endtask

  task automatic zero_register_tests();
    issue(i_format(12'd55, 5'd0, 3'd0, 5'd0));
    // Must not pick up the discarded x0 result
    issue(i_format(12'd0, 5'd0, 3'd0, 5'd27));
    issue(u_format(20'habcde, 5'd0));
    issue(r_format(7'h00, 5'd0, 5'd0, 3'd0, 5'd28));
    issue(r_format(7'h00, 5'd1, 5'd1, 3'd0, 5'd0));
    issue(r_format(7'h00, 5'd1, 5'd0, 3'd6, 5'd29));
    idle(2);
  endtask

  task automatic illegal_tests();
    // Load, all zeros, all ones
    issue(32'h0000_2083);
    issue(32'h0000_0000);
    issue(32'hffff_ffff);
    // MUL, SLLI with funct7 0x20, AND with funct7 0x20
    issue(r_format(7'h01, 5'd2, 5'd1, 3'd0, 5'd3));
    issue(i_format(12'h401, 5'd1, 3'd1, 5'd4));
    issue(r_format(7'h20, 5'd2, 5'd1, 3'd7, 5'd5));
    // Targets of the illegal ones still hold old values
    issue(r_format(7'h00, 5'd4, 5'd3, 3'd0, 5'd30));
    issue(r_format(7'h00, 5'd5, 5'd1, 3'd4, 5'd31));
    idle(2);
  endtask

  task automatic random_tests();
    int gap;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      issue(random_instr());
      gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, MAX_GAP) : 0;
      if (gap > 0)
        idle(gap);
    end
    idle(1);
  endtask

  //////////////////////////////
  // Result comparison
  //////////////////////////////

  // Sample just after the edge, outputs settled
  always begin : compare_results
    expect_t e;
    @(posedge clk_i);
    #1;
    if (wb_valid_o === 1'b1) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("A result retired with no instruction pending");
      end else begin
        e = exp_q.pop_front();
        check_val("wb_rd_o", wb_rd_o, e.rd);
        check_val("wb_we_o", wb_we_o, e.we);
        check_val("wb_illegal_o", wb_illegal_o, e.illegal);
        if (!e.illegal)
          check_val("wb_data_o", wb_data_o, e.data);
      end
    end
  end

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin : stimulus
    longint expected_count;
    rst_i         = 1'b1;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    void'($urandom(SEED));
    clear_shadow();
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    immediate_tests();
    register_tests();
    forwarding_tests();
    zero_register_tests();
    illegal_tests();
    random_tests();

    // Last result retires within the pipeline depth
    repeat (PIPE_DEPTH) @(posedge clk_i);
    @(negedge clk_i);

    expected_count = issued % (64'd1 << RETIRE_CNT_W);
    check_val("pending expectations", exp_q.size(), 0);
    check_val("retire_count_o", 32'(retire_count_o), 32'(expected_count));
    if (uut.asserts_i.fail_cnt == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_with_failure("Port assertions reported failures during the run");
    end
  end

endmodule

//--- vlog.f
+incdir+testbench
common/core_pkg.sv
common/pipe_if.sv
hw/decode/register_file.sv
hw/decode/decode_stage.sv
hw/execute/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
testbench/core_asserts.sv
testbench/tb_core.sv
